//--- common/branch_pkg.sv
// Shared branch types and RV32I opcode constants that cover only JAL, JALR and the six conditional branches
`default_nettype none

package branch_pkg;

  // Branch operation as seen by decode, target and the top level
  typedef enum logic [3:0] {
    JAL,
    JALR,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    NONE
  } instr_name_e;

  // One instruction word read both as B-type and as J-type
  // The JALR I-type immediate sits in the top 12 bits of the J-type layout
  typedef union packed {
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_word_u;

  // Major opcodes
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Conditional branch funct3 encodings, 3'b010 and 3'b011 are reserved
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

//--- logic/branch_decode.sv
// Combinational decode of branch and jump words only, anything else is flagged illegal with a zero immediate
`timescale 1ns/1ps
`default_nettype none

module branch_decode
  import branch_pkg::*;
(
  input  wire logic [31:0] i_instr,
  output instr_name_e      o_instr_name,
  output logic      [31:0] o_immediate,
  output logic             o_illegal
);

  instr_word_u word;
  instr_name_e name;
  logic [31:0] imm;
  logic        legal_op;

  assign word = i_instr;

  always_comb begin
    name = NONE;
    imm  = 32'h0;

    case (word.b_fmt.opcode)
      OPC_BRANCH: begin
        case (word.b_fmt.funct3)
          F3_BEQ:  name = BEQ;
          F3_BNE:  name = BNE;
          F3_BLT:  name = BLT;
          F3_BGE:  name = BGE;
          F3_BLTU: name = BLTU;
          F3_BGEU: name = BGEU;
          default: name = NONE;
        endcase
        if (name != NONE) begin
          imm = {{20{word.b_fmt.imm12}},
                 word.b_fmt.imm11,
                 word.b_fmt.imm10_5,
                 word.b_fmt.imm4_1,
                 1'b0};
        end
      end
      OPC_JAL: begin
        name = JAL;
        imm  = {{12{word.j_fmt.imm20}},
                word.j_fmt.imm19_12,
                word.j_fmt.imm11,
                word.j_fmt.imm10_1,
                1'b0};
      end
      OPC_JALR: begin
        // I-type immediate is instr[31:20]
        name = JALR;
        imm  = {{20{word.j_fmt.imm20}},
                word.j_fmt.imm20,
                word.j_fmt.imm10_1,
                word.j_fmt.imm11};
      end
      default: begin
        name = NONE;
        imm  = 32'h0;
      end
    endcase

    // Legality is derived from the raw fields and not from the case above
    legal_op = (word.j_fmt.opcode == OPC_JAL) ||
               (word.j_fmt.opcode == OPC_JALR) ||
               ((word.b_fmt.opcode == OPC_BRANCH) && (word.b_fmt.funct3[2:1] != 2'b01));

    assert (legal_op == (name != NONE))
      else $error("decode mismatch between illegal flag and operation for %h", i_instr);

    o_instr_name = name;
    o_immediate  = imm;
    o_illegal    = !legal_op;
  end

endmodule

`default_nettype wire

//--- branch/branch_target.sv
// Combinational target and link computation that expects a decoded operation and a sign-extended immediate
`timescale 1ns/1ps
`default_nettype none

module branch_target
  import branch_pkg::*;
(
  input  wire logic [31:0] i_data_1,
  input  wire logic [31:0] i_data_2,
  input  wire logic [31:0] i_address,
  input  wire logic [31:0] i_immediate,
  input  wire instr_name_e i_instr_name,
  output logic      [31:0] o_jump_result,
  output logic      [31:0] o_store_result
);

  logic [31:0] seq_pc;
  logic [31:0] rel_target;
  logic [31:0] reg_target;
  logic        equal;
  logic        less_s;
  logic        less_u;
  logic        taken;

  assign seq_pc     = i_address + 32'd4;
  assign rel_target = i_address + i_immediate;

  // JALR drops bit 0 of the sum
  assign reg_target = (i_data_1 + i_immediate) & ~32'd1;

  assign equal  = (i_data_1 == i_data_2);
  assign less_s = ($signed(i_data_1) < $signed(i_data_2));
  assign less_u = (i_data_1 < i_data_2);

  always_comb begin
    case (i_instr_name)
      BEQ:     taken = equal;
      BNE:     taken = !equal;
      BLT:     taken = less_s;
      BGE:     taken = !less_s;
      BLTU:    taken = less_u;
      BGEU:    taken = !less_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (i_instr_name)
      JAL: begin
        o_jump_result = rel_target;
      end
      JALR: begin
        o_jump_result = reg_target;
      end
      BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
        o_jump_result = taken ? rel_target : seq_pc;
      end
      default: begin
        // Non-branch falls through to the next word
        o_jump_result = seq_pc;
      end
    endcase
  end

  // Link value is the return address for every operation
  assign o_store_result = seq_pc;

endmodule

`default_nettype wire

//--- branch/branch_resolve.sv
// Single register stage with no back-pressure, flags are valid only with o_valid and C_EXT relaxes alignment to 2 bytes
`timescale 1ns/1ps
`default_nettype none

module branch_resolve #(
  parameter bit C_EXT = 1'b0
) (
  input  wire logic        i_clk,
  input  wire logic        i_arst_n,
  input  wire logic        i_valid,
  input  wire logic        i_illegal,
  input  wire logic        i_link,
  input  wire logic [31:0] i_jump_result,
  input  wire logic [31:0] i_store_result,
  input  wire logic [31:0] i_pred_pc,
  output logic             o_valid,
  output logic             o_redirect,
  output logic             o_misaligned,
  output logic             o_illegal,
  output logic             o_rd_write,
  output logic      [31:0] o_next_pc,
  output logic      [31:0] o_rd_data
);

  logic redirect_d;
  logic misaligned_d;

  assign redirect_d = (i_jump_result != i_pred_pc);

  // Bit 1 only matters when every target has to be word aligned
  assign misaligned_d = i_jump_result[1] && !C_EXT;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid      <= 1'b0;
      o_redirect   <= 1'b0;
      o_misaligned <= 1'b0;
      o_illegal    <= 1'b0;
      o_rd_write   <= 1'b0;
    end else begin
      o_valid      <= i_valid;
      o_redirect   <= i_valid && redirect_d;
      o_misaligned <= i_valid && misaligned_d;
      o_illegal    <= i_valid && i_illegal;
      o_rd_write   <= i_valid && i_link && !i_illegal;
    end
  end

  // Data holds its last value between strobes
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_next_pc <= 32'h0;
      o_rd_data <= 32'h0;
    end else if (i_valid) begin
      o_next_pc <= i_jump_result;
      o_rd_data <= i_store_result;
    end
  end

  // Flags stay low whenever there is no result
  a_flags_need_valid: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    !o_valid |-> !(o_redirect || o_misaligned || o_illegal || o_rd_write)
  ) else $error("flag high without o_valid");

  // With compressed support no 2-byte aligned target is a fault
  a_no_misalign_c_ext: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    C_EXT |-> !o_misaligned
  ) else $error("o_misaligned raised while C_EXT is set");

endmodule

`default_nettype wire

//--- logic/branch_exec_top.sv
// Branch execution stage with one cycle of latency that accepts an instruction on every valid strobe
`timescale 1ns/1ps
`default_nettype none

module branch_exec_top
  import branch_pkg::*;
#(
  parameter bit C_EXT = 1'b0
) (
  input  wire logic        i_clk,
  input  wire logic        i_arst_n,
  input  wire logic        i_valid,
  input  wire logic [31:0] i_instr,
  input  wire logic [31:0] i_pc,
  input  wire logic [31:0] i_rs1_data,
  input  wire logic [31:0] i_rs2_data,
  input  wire logic [31:0] i_pred_pc,
  output logic             o_valid,
  output logic             o_redirect,
  output logic             o_misaligned,
  output logic             o_illegal,
  output logic             o_rd_write,
  output logic      [31:0] o_next_pc,
  output logic      [31:0] o_rd_data
);

  instr_name_e instr_name;
  logic [31:0] immediate;
  logic        illegal;
  logic        link;
  logic [31:0] jump_result;
  logic [31:0] store_result;

  branch_decode u_decode (
    .i_instr      (i_instr),
    .o_instr_name (instr_name),
    .o_immediate  (immediate),
    .o_illegal    (illegal)
  );

  branch_target u_target (
    .i_data_1       (i_rs1_data),
    .i_data_2       (i_rs2_data),
    .i_address      (i_pc),
    .i_immediate    (immediate),
    .i_instr_name   (instr_name),
    .o_jump_result  (jump_result),
    .o_store_result (store_result)
  );

  // Only the jumps write a link register
  assign link = (instr_name == JAL) || (instr_name == JALR);

  branch_resolve #(
    .C_EXT (C_EXT)
  ) u_resolve (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_valid        (i_valid),
    .i_illegal      (illegal),
    .i_link         (link),
    .i_jump_result  (jump_result),
    .i_store_result (store_result),
    .i_pred_pc      (i_pred_pc),
    .o_valid        (o_valid),
    .o_redirect     (o_redirect),
    .o_misaligned   (o_misaligned),
    .o_illegal      (o_illegal),
    .o_rd_write     (o_rd_write),
    .o_next_pc      (o_next_pc),
    .o_rd_data      (o_rd_data)
  );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
// Free-running testbench clock that starts low, PERIOD_NS should be an even number of ns
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

//--- bench/branch_tasks.svh
// Included inside branch_tb and uses its signals, expected values assume a DUT built with C_EXT at 0
`ifndef BRANCH_TASKS_SVH
`define BRANCH_TASKS_SVH

// Operand pairs are equal, less, greater, then both sides of the sign boundary
localparam logic [31:0] PAIR_A [6] = '{32'd5, 32'd3, 32'd7,
                                       32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
localparam logic [31:0] PAIR_B [6] = '{32'd5, 32'd7, 32'd3,
                                       32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001};

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
  check_count++;
  if (expected !== actual) begin
    error_count++;
    $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
  end
endtask

// Reference model written from the RV32I rules for jumps and branches
function automatic void predict_result(input instr_name_e op, input logic [31:0] pc,
                                       input logic [31:0] rs1, input logic [31:0] rs2,
                                       input logic [31:0] imm, input logic [31:0] pred);
  logic        taken;
  logic [31:0] sum;
  case (op)
    BEQ:     taken = (rs1 == rs2);
    BNE:     taken = (rs1 != rs2);
    BLT:     taken = ($signed(rs1) < $signed(rs2));
    BGE:     taken = ($signed(rs1) >= $signed(rs2));
    BLTU:    taken = (rs1 < rs2);
    BGEU:    taken = (rs1 >= rs2);
    default: taken = (op == JAL);
  endcase
  sum = rs1 + imm;
  if (op == JALR) begin
    exp_next_pc = {sum[31:1], 1'b0};
  end else if (taken) begin
    exp_next_pc = pc + imm;
  end else begin
    exp_next_pc = pc + 32'd4;
  end
  exp_rd_data    = pc + 32'd4;
  exp_rd_write   = (op == JAL) || (op == JALR);
  exp_redirect   = (exp_next_pc != pred);
  exp_misaligned = exp_next_pc[1];
  exp_illegal    = (op == NONE);
endfunction

// NONE is encoded as a branch with the reserved funct3 of 2
function automatic logic [31:0] encode_word(input instr_name_e op, input logic [31:0] imm);
  logic [2:0]  f3;
  logic [31:0] word;
  case (op)
    BEQ:     f3 = F3_BEQ;
    BNE:     f3 = F3_BNE;
    BLT:     f3 = F3_BLT;
    BGE:     f3 = F3_BGE;
    BLTU:    f3 = F3_BLTU;
    BGEU:    f3 = F3_BGEU;
    default: f3 = 3'b010;
  endcase
  case (op)
    JAL:     word = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    JALR:    word = {imm[11:0], 5'd1, 3'b000, 5'd1, OPC_JALR};
    default: word = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endcase
  return word;
endfunction

function automatic logic [31:0] rand_imm(input instr_name_e op);
  logic [31:0] r;
  logic [31:0] imm;
  r = $urandom;
  if (op == JAL) begin
    imm = {{11{r[20]}}, r[20:1], 1'b0};
  end else if (op == JALR) begin
    imm = {{20{r[11]}}, r[11:0]};
  end else begin
    imm = {{19{r[12]}}, r[12:1], 1'b0};
  end
  return imm;
endfunction

task automatic drive_inputs(input logic [31:0] word, input logic [31:0] pc,
                            input logic [31:0] rs1, input logic [31:0] rs2,
                            input logic [31:0] pred);
  i_instr    = word;
  i_pc       = pc;
  i_rs1_data = rs1;
  i_rs2_data = rs2;
  i_pred_pc  = pred;
endtask

task automatic check_quiet();
  compare_value("o_valid", 32'd0, 32'(o_valid));
  compare_value("o_redirect", 32'd0, 32'(o_redirect));
  compare_value("o_misaligned", 32'd0, 32'(o_misaligned));
  compare_value("o_illegal", 32'd0, 32'(o_illegal));
  compare_value("o_rd_write", 32'd0, 32'(o_rd_write));
endtask

task automatic check_outputs();
  compare_value("o_valid", 32'd1, 32'(o_valid));
  compare_value("o_next_pc", exp_next_pc, o_next_pc);
  compare_value("o_rd_data", exp_rd_data, o_rd_data);
  compare_value("o_rd_write", 32'(exp_rd_write), 32'(o_rd_write));
  compare_value("o_redirect", 32'(exp_redirect), 32'(o_redirect));
  compare_value("o_misaligned", 32'(exp_misaligned), 32'(o_misaligned));
  compare_value("o_illegal", 32'(exp_illegal), 32'(o_illegal));
endtask

// Called on a falling edge, the result is due there already
task automatic wait_valid();
  int cycles;
  cycles = 0;
  while (!o_valid && cycles < VALID_TIMEOUT) begin
    @(negedge i_clk);
    cycles++;
  end
  if (!o_valid) begin
    $display("TIMEOUT o_valid did not rise within %0d cycles", VALID_TIMEOUT);
    error_count++;
    finish_report();
  end else if (cycles != 0) begin
    $display("Result came %0d cycles later than the one cycle latency", cycles);
    error_count++;
  end
endtask

task automatic run_one(input instr_name_e op, input logic [31:0] word,
                       input logic [31:0] pc, input logic [31:0] rs1,
                       input logic [31:0] rs2, input logic [31:0] imm,
                       input logic [31:0] pred);
  @(negedge i_clk);
  drive_inputs(word, pc, rs1, rs2, pred);
  i_valid = 1'b1;
  predict_result(op, pc, rs1, rs2, imm, pred);
  @(negedge i_clk);
  i_valid = 1'b0;
  wait_valid();
  check_outputs();
endtask

task automatic test_cond_branches();
  instr_name_e op;
  logic [31:0] imm;
  logic [31:0] pc;
  for (int k = 0; k < 6; k++) begin
    op = instr_name_e'(4'(k + 2));
    for (int n = 0; n < 6; n++) begin
      imm = rand_imm(op);
      pc  = $urandom & 32'hffff_fffc;
      run_one(op, encode_word(op, imm), pc, PAIR_A[n], PAIR_B[n], imm, pc + 32'd4);
      compare_value("o_rd_write", 32'd0, 32'(o_rd_write));
    end
  end
endtask

task automatic test_jumps();
  logic [31:0] pc;
  pc = 32'h0000_2000;
  run_one(JAL, encode_word(JAL, 32'hffff_fff8), pc, 32'h0, 32'h0, 32'hffff_fff8, pc + 32'd4);
  run_one(JAL, encode_word(JAL, 32'hfff0_0000), pc, 32'h0, 32'h0, 32'hfff0_0000, pc);
  run_one(JALR, encode_word(JALR, 32'hffff_fffc), pc, 32'h1000, 32'h0, 32'hffff_fffc,
          32'h0000_0ffc);
  // Odd sums lose bit 0
  run_one(JALR, encode_word(JALR, 32'hffff_fffe), pc, 32'h2003, 32'h0, 32'hffff_fffe, pc);
  run_one(JALR, encode_word(JALR, 32'hffff_f800), pc, 32'h1801, 32'h0, 32'hffff_f800,
          pc + 32'd4);
  compare_value("o_rd_write", 32'd1, 32'(o_rd_write));
endtask

task automatic check_prediction(input instr_name_e op, input logic [31:0] pred,
                                input logic want);
  run_one(op, encode_word(op, 32'h40), 32'h100, 32'h55, 32'h55, 32'h40, pred);
  compare_value("o_redirect", 32'(want), 32'(o_redirect));
endtask

task automatic test_prediction();
  check_prediction(BEQ, 32'h140, 1'b0);
  check_prediction(BEQ, 32'h104, 1'b1);
  check_prediction(BNE, 32'h104, 1'b0);
  check_prediction(BNE, 32'h140, 1'b1);
endtask

task automatic test_faults();
  logic [31:0] word;
  word = encode_word(BEQ, 32'h10);
  word[14:12] = 3'b011;
  run_one(NONE, encode_word(NONE, 32'h10), 32'h300, 32'h1, 32'h1, 32'h10, 32'h304);
  compare_value("o_illegal", 32'd1, 32'(o_illegal));
  run_one(NONE, word, 32'h300, 32'h1, 32'h1, 32'h10, 32'h304);
  compare_value("o_illegal", 32'd1, 32'(o_illegal));
  // A register add is not a branch
  run_one(NONE, 32'h0020_80b3, 32'h300, 32'h1, 32'h2, 32'h0, 32'h304);
  compare_value("o_illegal", 32'd1, 32'(o_illegal));
  run_one(JALR, encode_word(JALR, 32'h2), 32'h300, 32'h1000, 32'h0, 32'h2, 32'h1002);
  compare_value("o_misaligned", 32'd1, 32'(o_misaligned));
endtask

task automatic test_streaming();
  instr_name_e op;
  logic [31:0] pc;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [31:0] imm;
  logic [31:0] pred;
  int          results;
  results = 0;
  for (int n = 0; n <= 50; n++) begin
    @(negedge i_clk);
    if (n > 0) begin
      check_outputs();
      if (o_valid) begin
        results++;
      end
    end
    if (n < 50) begin
      op  = instr_name_e'(4'($urandom_range(8, 0)));
      imm = rand_imm(op);
      pc  = $urandom & 32'hffff_fffc;
      rs1 = $urandom;
      rs2 = ($urandom_range(3, 0) == 0) ? rs1 : $urandom;
      predict_result(op, pc, rs1, rs2, imm, 32'h0);
      pred = ($urandom_range(1, 0) == 1) ? exp_next_pc : pc + 32'd4;
      predict_result(op, pc, rs1, rs2, imm, pred);
      drive_inputs(encode_word(op, imm), pc, rs1, rs2, pred);
      i_valid = 1'b1;
    end else begin
      i_valid = 1'b0;
    end
  end
  @(negedge i_clk);
  check_quiet();
  compare_value("valid results", 32'd50, 32'(results));
endtask

`endif

//--- bench/branch_tb.sv
// Directed testbench for a DUT built with C_EXT at 0, inputs change on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module branch_tb
  import branch_pkg::*;
();

  localparam int VALID_TIMEOUT = 8;

  logic        i_clk;
  logic        i_arst_n;
  logic        i_valid;
  logic [31:0] i_instr;
  logic [31:0] i_pc;
  logic [31:0] i_rs1_data;
  logic [31:0] i_rs2_data;
  logic [31:0] i_pred_pc;
  logic        o_valid;
  logic        o_redirect;
  logic        o_misaligned;
  logic        o_illegal;
  logic        o_rd_write;
  logic [31:0] o_next_pc;
  logic [31:0] o_rd_data;

  // Expected result of the instruction in flight
  logic [31:0] exp_next_pc;
  logic [31:0] exp_rd_data;
  logic        exp_rd_write;
  logic        exp_redirect;
  logic        exp_misaligned;
  logic        exp_illegal;

  int check_count = 0;
  int error_count = 0;

  clk_gen #(
    .PERIOD_NS (4)
  ) u_clk_gen (
    .o_clk (i_clk)
  );

  branch_exec_top #(
    .C_EXT (1'b0)
  ) uut (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_valid),
    .i_instr      (i_instr),
    .i_pc         (i_pc),
    .i_rs1_data   (i_rs1_data),
    .i_rs2_data   (i_rs2_data),
    .i_pred_pc    (i_pred_pc),
    .o_valid      (o_valid),
    .o_redirect   (o_redirect),
    .o_misaligned (o_misaligned),
    .o_illegal    (o_illegal),
    .o_rd_write   (o_rd_write),
    .o_next_pc    (o_next_pc),
    .o_rd_data    (o_rd_data)
  );

  `include "branch_tasks.svh"

  task automatic finish_report();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Reset is held over three rising edges, then released on a falling edge
  task automatic test_reset();
    for (int n = 0; n < 3; n++) begin
      @(negedge i_clk);
      check_quiet();
      compare_value("o_next_pc", 32'h0, o_next_pc);
      compare_value("o_rd_data", 32'h0, o_rd_data);
    end
    i_arst_n = 1'b1;
    repeat (2) begin
      @(negedge i_clk);
      check_quiet();
    end
  endtask

  initial begin
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_instr    = 32'h0;
    i_pc       = 32'h0;
    i_rs1_data = 32'h0;
    i_rs2_data = 32'h0;
    i_pred_pc  = 32'h0;
    void'($urandom(32'h6e9b6d0d));
    test_reset();
    test_cond_branches();
    test_jumps();
    test_prediction();
    test_faults();
    test_streaming();
    @(negedge i_clk);
    finish_report();
  end

endmodule

`default_nettype wire

//--- branch_exec.f
+incdir+bench
common/branch_pkg.sv
logic/branch_decode.sv
branch/branch_target.sv
branch/branch_resolve.sv
logic/branch_exec_top.sv
bench/clk_gen.sv
bench/branch_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module branch_tb \
  -f branch_exec.f \
  -Mdir obj_dir -o branch_sim

./obj_dir/branch_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
